//--- source/t07_defines.svh
`ifndef T07_DEFINES_SVH
`define T07_DEFINES_SVH

// active frame, one pixel per clock
`define T07_H_ACTIVE      320 // visible columns
`define T07_V_ACTIVE      240 // visible rows

// heart column placement
`define T07_HEART_X       260 // left column of every heart box
`define T07_HEART_Y       200 // top row of heart 1
`define T07_HEART_SPACING 30  // heart k sits this far above heart k-1
`define T07_HEART_SIZE    21  // square sprite box edge

`define T07_MAX_LIVES     3   // count after reset or restart

`endif

//--- source/t07_pkg.sv
package t07_pkg;

  // one screen position as produced by the scanner
  typedef struct packed {
    logic [8:0] x; // column 0..319
    logic [7:0] y; // row 0..239
  } pixelCoord_t;

  // game progress as seen by the overlay
  typedef enum logic {
    statePlay = 1'b0, // lives left, hits counted
    stateOver = 1'b1  // out of lives, hits ignored
  } gameState_t;

endpackage

//--- source/t07_pixelScan.sv
`timescale 1ns/1ps
`include "t07_defines.svh"

module t07_pixelScan (
  input  logic                 clk,
  input  logic                 nrst,
  output t07_pkg::pixelCoord_t scanPos,
  output logic                 frameEnd
);

  logic [8:0] col;
  logic [8:0] colNext;
  logic [7:0] row;
  logic [7:0] rowNext;
  logic       lastCol;
  logic       lastRow;

  assign lastCol = (col == 9'(`T07_H_ACTIVE - 1)); // column 319
  assign lastRow = (row == 8'(`T07_V_ACTIVE - 1)); // row 239

  // raster order, left to right then top to bottom
  always_comb begin
    colNext = col + 9'd1;
    rowNext = row;
    if (lastCol) begin
      colNext = '0;
      if (lastRow) begin
        rowNext = '0; // back to the top left corner
      end else begin
        rowNext = row + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      col <= '0;
      row <= '0;
    end else begin
      col <= colNext;
      row <= rowNext;
    end
  end

  assign scanPos.x = col;
  assign scanPos.y = row;

  // last pixel of the frame, single cycle
  assign frameEnd = lastCol && lastRow;

endmodule

//--- source/t07_livesTracker.sv
`timescale 1ns/1ps
`include "t07_defines.svh"

module t07_livesTracker (
  input  logic       clk,
  input  logic       nrst,
  input  logic       hit,
  input  logic       restart,
  input  logic       frameEnd,
  output logic [1:0] lives,
  output logic       gameOver
);

  t07_pkg::gameState_t state;
  t07_pkg::gameState_t stateNext;
  logic [1:0]          livesNext;
  logic                pending;
  logic                pendingNext;
  logic                hitAccept;
  logic                lastLife;

  assign hitAccept = hit && (state == t07_pkg::statePlay); // dead players take no hits
  assign lastLife  = (lives == 2'd1);

  // a hit only waits here; the count moves at the frame boundary so
  // every frame is drawn with one value
  always_comb begin
    stateNext   = state;
    livesNext   = lives;
    pendingNext = pending || hitAccept; // repeated hits collapse
    if (restart) begin
      stateNext   = t07_pkg::statePlay; // wins over frameEnd
      livesNext   = 2'(`T07_MAX_LIVES);
      pendingNext = 1'b0;
    end else if (frameEnd && pending) begin
      livesNext   = lives - 2'd1;
      pendingNext = hitAccept && !lastLife; // hit on the boundary waits a frame
      if (lastLife) begin
        stateNext = t07_pkg::stateOver;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state   <= t07_pkg::statePlay;
      lives   <= 2'(`T07_MAX_LIVES);
      pending <= 1'b0;
    end else begin
      state   <= stateNext;
      lives   <= livesNext;
      pending <= pendingNext;
    end
  end

  assign gameOver = (state == t07_pkg::stateOver);

endmodule

//--- source/t07_generate_heart.sv
`timescale 1ns/1ps
`include "t07_defines.svh"

module t07_generate_heart (
  input  logic                 clk,
  input  logic                 nrst,
  input  t07_pkg::pixelCoord_t scanPos,
  input  logic [1:0]           lives,
  output logic                 heartPixel
);

  logic heartDetect;

  // inclusive column span test inside the sprite box
  function automatic logic inSpan(
    input logic [4:0] c,
    input logic [4:0] lo,
    input logic [4:0] hi
  );
    return (c >= lo) && (c <= hi);
  endfunction

  // sprite shape, r and c are offsets inside the 21x21 box
  function automatic logic heartShape(
    input logic [4:0] r,
    input logic [4:0] c,
    input logic       cracked
  );
    logic       lit;
    logic [4:0] lo1;
    logic [4:0] hi1;
    logic [4:0] lo2;
    logic [4:0] hi2;
    lit = 1'b0;
    lo1 = 5'd31; // empty spans unless a row sets them
    hi1 = 5'd0;
    lo2 = 5'd31;
    hi2 = 5'd0;
    if (r <= 5'd8) begin
      lit = inSpan(c, 5'd10 - r, 5'd10 + r); // top point widening downward
    end else if (r == 5'd19) begin
      lit = inSpan(c, 5'd3, 5'd8) || inSpan(c, 5'd12, 5'd17);
    end else if (r == 5'd20) begin
      lit = inSpan(c, 5'd5, 5'd7) || inSpan(c, 5'd13, 5'd15);
    end else if (!cracked) begin
      case (r)
        5'd9, 5'd10, 5'd16, 5'd17: begin
          lit = inSpan(c, 5'd1, 5'd19);
        end
        5'd18: begin
          lit = inSpan(c, 5'd2, 5'd9) || inSpan(c, 5'd11, 5'd18);
        end
        default: begin
          lit = inSpan(c, 5'd0, 5'd20); // rows 11 to 15, full width
        end
      endcase
    end else begin
      // zigzag gap running down the middle of the fill
      case (r)
        5'd9: begin
          lo1 = 5'd1;
          hi1 = 5'd10;
          lo2 = 5'd12;
          hi2 = 5'd19;
        end
        5'd10: begin
          lo1 = 5'd1;
          hi1 = 5'd9;
          lo2 = 5'd12;
          hi2 = 5'd19;
        end
        5'd11: begin
          lo1 = 5'd0;
          hi1 = 5'd9;
          lo2 = 5'd11;
          hi2 = 5'd20;
        end
        5'd12, 5'd14: begin
          lo1 = 5'd0;
          hi1 = 5'd8;
          lo2 = 5'd11;
          hi2 = 5'd20;
        end
        5'd13: begin
          lo1 = 5'd0;
          hi1 = 5'd7;
          lo2 = 5'd10;
          hi2 = 5'd20;
        end
        5'd15: begin
          lo1 = 5'd0;
          hi1 = 5'd9;
          lo2 = 5'd12;
          hi2 = 5'd20;
        end
        5'd16: begin
          lo1 = 5'd1;
          hi1 = 5'd10;
          lo2 = 5'd13;
          hi2 = 5'd19;
        end
        5'd17: begin
          lo1 = 5'd1;
          hi1 = 5'd9;
          lo2 = 5'd12;
          hi2 = 5'd19;
        end
        5'd18: begin
          lo1 = 5'd2;
          hi1 = 5'd8;
          lo2 = 5'd11;
          hi2 = 5'd18;
        end
        default: begin
          lo1 = 5'd31; // outside the fill band
        end
      endcase
      lit = inSpan(c, lo1, hi1) || inSpan(c, lo2, hi2);
    end
    return lit;
  endfunction

  // three boxes stacked upward from heart 1
  always_comb begin
    logic [7:0] boxTop;
    logic [7:0] rowOff;
    logic [8:0] colOff;
    logic       inBox;
    logic       cracked;
    heartDetect = 1'b0;
    colOff      = scanPos.x - 9'(`T07_HEART_X); // wraps high left of the box
    for (int k = 0; k < 3; k++) begin
      boxTop  = 8'(`T07_HEART_Y - k * `T07_HEART_SPACING);
      rowOff  = scanPos.y - boxTop;
      inBox   = (colOff < 9'(`T07_HEART_SIZE)) && (rowOff < 8'(`T07_HEART_SIZE));
      cracked = (2'(k + 1) > lives); // heart 3 goes first
      heartDetect = heartDetect
                    || (inBox && heartShape(rowOff[4:0], colOff[4:0], cracked));
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      heartPixel <= 1'b0;
    end else begin
      heartPixel <= heartDetect; // one clock behind scanPos
    end
  end

endmodule

//--- source/t07_heartDisplay.sv
`timescale 1ns/1ps

module t07_heartDisplay (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 hit,
  input  logic                 restart,
  output t07_pkg::pixelCoord_t scanPos,
  output logic                 heartPixel,
  output logic [1:0]           lives,
  output logic                 gameOver
);

  logic frameEnd; // last pixel strobe to the tracker

  t07_pixelScan scanner (
    .clk      (clk),
    .nrst     (nrst),
    .scanPos  (scanPos),
    .frameEnd (frameEnd)
  );

  // count only moves at frame boundaries
  t07_livesTracker tracker (
    .clk      (clk),
    .nrst     (nrst),
    .hit      (hit),
    .restart  (restart),
    .frameEnd (frameEnd),
    .lives    (lives),
    .gameOver (gameOver)
  );

  t07_generate_heart renderer (
    .clk        (clk),
    .nrst       (nrst),
    .scanPos    (scanPos),
    .lives      (lives),
    .heartPixel (heartPixel)
  );

endmodule

//--- sim/t07_heartDisplay_tb.sv
`timescale 1ns/1ps
`include "t07_defines.svh"

module t07_heartDisplay_tb;

  localparam longint FrameCycles = `T07_H_ACTIVE * `T07_V_ACTIVE;
  localparam longint TimeoutNs   = 12 * FrameCycles * 8; // 12 frames at 8 ns per pixel

  logic                 clk;
  logic                 nrst;
  logic                 hit;
  logic                 restart;
  t07_pkg::pixelCoord_t scanPos;
  logic                 heartPixel;
  logic [1:0]           lives;
  logic                 gameOver;

  // previous cycle as the renderer saw it
  t07_pkg::pixelCoord_t prevPos;
  logic [1:0]           prevLives;
  logic                 prevRestart;
  logic                 prevValid;

  t07_heartDisplay UUT (
    .clk        (clk),
    .nrst       (nrst),
    .hit        (hit),
    .restart    (restart),
    .scanPos    (scanPos),
    .heartPixel (heartPixel),
    .lives      (lives),
    .gameOver   (gameOver)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    prevPos     <= scanPos;
    prevLives   <= lives;
    prevRestart <= restart;
    prevValid   <= nrst; // first active cycle has no history
  end

  task automatic reportMismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at the first failing check");
  endtask

  // one 21x21 sprite box at offsets r and c
  function automatic bit spriteLit(input int r, input int c, input bit cracked);
    int lo;
    int hi;
    int gapLo;
    int gapHi;
    if (r < 0 || r > 20 || c < 0 || c > 20) return 1'b0;
    if (r <= 8) return (c >= 10 - r) && (c <= 10 + r); // pointed top
    if (r == 19) return (c >= 3 && c <= 8) || (c >= 12 && c <= 17);
    if (r == 20) return (c >= 5 && c <= 7) || (c >= 13 && c <= 15);
    lo    = (r >= 11 && r <= 15) ? 0 : ((r == 18) ? 2 : 1); // outer edge of the fill
    hi    = 20 - lo;
    gapLo = (r == 18) ? 10 : 99;
    gapHi = gapLo;
    if (cracked) begin
      case (r) // first dark crack column per fill row
        9:       gapLo = 11;
        11:      gapLo = 10;
        12, 14:  gapLo = 9;
        13:      gapLo = 8;
        16:      gapLo = 11;
        18:      gapLo = 9;
        default: gapLo = 10; // rows 10, 15, 17
      endcase
      gapHi = (r == 9 || r == 11) ? gapLo : gapLo + 1; // one column wide on rows 9 and 11
    end
    return (c >= lo) && (c <= hi) && !((c >= gapLo) && (c <= gapHi));
  endfunction

  function automatic bit expectPixel(input t07_pkg::pixelCoord_t p, input logic [1:0] lv);
    bit lit;
    int top;
    lit = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      top = `T07_HEART_Y - (k - 1) * `T07_HEART_SPACING;
      lit = lit || spriteLit(int'(p.y) - top, int'(p.x) - `T07_HEART_X, k > int'(lv));
    end
    return lit;
  endfunction

  function automatic bit inAnyBox(input t07_pkg::pixelCoord_t p);
    bit hitBox;
    int r;
    int c;
    hitBox = 1'b0;
    c = int'(p.x) - `T07_HEART_X;
    for (int k = 1; k <= 3; k++) begin
      r = int'(p.y) - (`T07_HEART_Y - (k - 1) * `T07_HEART_SPACING);
      hitBox = hitBox || (r >= 0 && r < `T07_HEART_SIZE && c >= 0 && c < `T07_HEART_SIZE);
    end
    return hitBox;
  endfunction

  function automatic t07_pkg::pixelCoord_t nextPos(input t07_pkg::pixelCoord_t p);
    t07_pkg::pixelCoord_t n;
    n = p;
    if (int'(p.x) == `T07_H_ACTIVE - 1) begin
      n.x = '0;
      n.y = (int'(p.y) == `T07_V_ACTIVE - 1) ? 8'd0 : p.y + 8'd1;
    end else begin
      n.x = p.x + 9'd1;
    end
    return n;
  endfunction

  scanStep: assert property (@(posedge clk) disable iff (!nrst)
    prevValid |-> scanPos == nextPos(prevPos))
    else reportMismatch("scanPos did not advance by one pixel in raster order");

  pixelModel: assert property (@(posedge clk) disable iff (!nrst)
    heartPixel == expectPixel(prevPos, prevLives))
    else reportMismatch("heartPixel differs from the sprite model");

  pixelBounds: assert property (@(posedge clk) disable iff (!nrst)
    heartPixel |-> inAnyBox(prevPos))
    else reportMismatch("heartPixel lit outside the heart boxes");

  // only restart may move the count away from a frame boundary
  livesStep: assert property (@(posedge clk) disable iff (!nrst)
    (prevValid && !prevRestart && lives != prevLives)
      |-> (scanPos == '0 && lives == prevLives - 2'd1))
    else reportMismatch("lives changed off the frame boundary or by more than one");

  overFlag: assert property (@(posedge clk) disable iff (!nrst)
    gameOver == (lives == 2'd0))
    else reportMismatch("gameOver does not match a count of zero");

  task automatic waitCycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic waitPos(input logic [8:0] x, input logic [7:0] y);
    while (scanPos.x != x || scanPos.y != y) @(negedge clk);
  endtask

  task automatic pulseHit();
    hit = 1'b1;
    @(negedge clk);
    hit = 1'b0;
  endtask

  task automatic pulseRestart();
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
  endtask

  // row 13 of heart k is lit only when intact
  task automatic probeHeart(input int k, input int col, input bit expectLit);
    logic [8:0] px;
    logic [7:0] py;
    px = 9'(`T07_HEART_X + col);
    py = 8'(`T07_HEART_Y - (k - 1) * `T07_HEART_SPACING + 13);
    waitPos(px, py);
    @(negedge clk);
    assert (heartPixel == expectLit)
      else reportMismatch($sformatf("heart %0d probe at (%0d,%0d) expected %0b",
                                    k, px, py, expectLit));
  endtask

  task automatic probeHearts(input int lv);
    int col;
    col = 8 + int'($urandom % 2); // both inside the row 13 crack
    for (int k = 3; k >= 1; k--) begin
      probeHeart(k, col, k <= lv);
    end
  endtask

  task automatic endOfFrameCheck(input logic [1:0] expLives);
    waitPos(9'(`T07_H_ACTIVE - 1), 8'(`T07_V_ACTIVE - 1));
    assert (lives == expLives)
      else reportMismatch($sformatf("lives %0d before frame end, expected %0d",
                                    lives, expLives));
  endtask

  task automatic nextFrameCheck(input logic [1:0] expLives, input logic expOver);
    @(negedge clk);
    assert (scanPos == '0) else reportMismatch("scan did not return to (0,0)");
    assert (lives == expLives && gameOver == expOver)
      else reportMismatch($sformatf("frame start lives %0d gameOver %0b, expected %0d %0b",
                                    lives, gameOver, expLives, expOver));
  endtask

  initial begin
    #(TimeoutNs);
    $display("simulation timed out: the test sequence did not finish in 12 frames");
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk     = 1'b0;
    nrst    = 1'b0;
    hit     = 1'b0;
    restart = 1'b0;
    void'($urandom(31));
    repeat (10) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;
    assert (scanPos == '0 && lives == 2'd3 && !gameOver && !heartPixel)
      else reportMismatch("outputs after reset");

    // two hits in the frame at 3 lives collapse into one
    waitCycles(1 + int'($urandom % 20000));
    pulseHit();
    waitCycles(1 + int'($urandom % 20000));
    pulseHit();
    probeHearts(3);
    endOfFrameCheck(2'd3);
    nextFrameCheck(2'd2, 1'b0);

    // frame at 2 lives
    probeHearts(2);
    pulseHit();
    endOfFrameCheck(2'd2);
    nextFrameCheck(2'd1, 1'b0);

    // last hit in the frame at 1 life ends the game
    probeHearts(1);
    pulseHit();
    endOfFrameCheck(2'd1);
    nextFrameCheck(2'd0, 1'b1);

    // hits ignored after game over
    probeHearts(0);
    pulseHit();
    waitCycles(1 + int'($urandom % 1000));
    pulseHit();
    endOfFrameCheck(2'd0);
    nextFrameCheck(2'd0, 1'b1);

    // restart mid frame and again on frameEnd with a hit pending
    waitCycles(1 + int'($urandom % 30000));
    pulseRestart();
    assert (lives == 2'd3 && !gameOver) else reportMismatch("restart from game over");
    pulseHit();
    endOfFrameCheck(2'd3);
    pulseRestart();
    assert (scanPos == '0 && lives == 2'd3 && !gameOver)
      else reportMismatch("restart did not win over frameEnd with a pending hit");

    // all hearts intact again
    probeHearts(3);
    endOfFrameCheck(2'd3);
    nextFrameCheck(2'd3, 1'b0);

    $display("No errors");
    $finish;
  end

endmodule

//--- tb.f
+incdir+source
source/t07_pkg.sv
source/t07_pixelScan.sv
source/t07_livesTracker.sv
source/t07_generate_heart.sv
source/t07_heartDisplay.sv
sim/t07_heartDisplay_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the heart overlay testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module t07_heartDisplay_tb \
  -o t07_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/t07_sim > sim.log 2>&1
cat sim.log

# the testbench prints the fail message on every failing path
grep -q "Errors found" sim.log \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }
